// File: list.f
+incdir+common
+incdir+sim
common/tlb_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb_lookup.sv
source/addr_translate.sv
source/mmu_top.sv
sim/tb_mmu.sv

// File: Makefile
SIM = obj_dir/Vtb_mmu
SRCS = common/tlb_consts.svh common/tlb_pkg.sv tlb/tlb_entry_array.sv tlb/tlb_lookup.sv \
       source/addr_translate.sv source/mmu_top.sv sim/tb_mmu.sv sim/mmu_model.svh

$(SIM): list.f $(SRCS)
	verilator --binary --assert --timescale 1ns/10ps --top-module tb_mmu -f list.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: sim/mmu_model.svh
// shadow of the tlb, written when the dut samples wr
tlb_pkg::tlb_entry_t shadow [`TLB_NUM];

function automatic void shadow_clear();
    for (int i = 0; i < `TLB_NUM; i++) begin
        shadow[i] = '0;
    end
endfunction

function automatic void shadow_write(input tlb_pkg::tlb_wr_t w);
    if (w.we) begin
        shadow[w.index] = w.entry;
    end
endfunction

function automatic tlb_pkg::xlat_res_t expected_xlat(input logic pg_en,
        input logic [`TLB_ASID_LEN-1:0] cur_asid, input tlb_pkg::dmw_t w0,
        input tlb_pkg::dmw_t w1, input logic [`VA_LEN-1:0] va);
    tlb_pkg::xlat_res_t r;
    tlb_pkg::tlb_trans_t t;
    logic big;
    r = '0;
    r.hit = 1'b1;
    r.pa = va;
    if (!pg_en) begin
        return r;
    end
    r.mode = tlb_pkg::mode_dmw;
    if (w0.en && va[31:29] == w0.vseg) begin
        r.pa[31:29] = w0.pseg;  // dmw0 checked first
    end else if (w1.en && va[31:29] == w1.vseg) begin
        r.pa[31:29] = w1.pseg;
    end else begin
        r = '0;
        r.mode = tlb_pkg::mode_paged;
        r.miss = 1'b1;
        for (int i = 0; i < `TLB_NUM; i++) begin
            big = shadow[i].cmp.ps == `PS_2M;
            if (!shadow[i].cmp.e || !(shadow[i].cmp.g || shadow[i].cmp.asid == cur_asid)) begin
                continue;
            end
            if (big ? shadow[i].cmp.vppn[18:9] != va[31:22]
                    : shadow[i].cmp.vppn != va[31:13]) begin
                continue;
            end
            t = (big ? va[21] : va[12]) ? shadow[i].odd : shadow[i].even;
            r.hit = 1'b1;
            r.miss = 1'b0;
            r.pa = big ? {t.ppn[19:9], va[20:0]} : {t.ppn, va[11:0]};
            {r.v, r.d, r.mat, r.plv} = {t.v, t.d, t.mat, t.plv};
        end
    end
    return r;
endfunction

// File: sim/tb_mmu.sv
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tb_mmu;

    bit                         clk;
    logic                       rstn, pg;
    logic [`TLB_ASID_LEN-1:0]   asid;
    tlb_pkg::dmw_t              dmw0, dmw1;
    tlb_pkg::tlb_wr_t           wr;
    logic [`VA_LEN-1:0]         va_i, va_d;
    tlb_pkg::xlat_res_t         res_i, res_d;
    tlb_pkg::xlat_res_t         exp_i, exp_d;  // due at the next negedge
    integer                     seed;
    int                         n_err, n_cmp, n_tests;
    bit                         have_exp;

    `include "mmu_model.svh"

    mmu_top i_mmu_top (.*);

    always #20 clk = ~clk;

    task automatic check(input tlb_pkg::xlat_res_t got, input tlb_pkg::xlat_res_t exp,
                         input string msg);
        if (got !== exp) begin
            n_err++;
            $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // inputs change on posedge, so expected values are taken on negedge
    always @(negedge clk) begin
        if (!have_exp) begin
            exp_i = '0;
            exp_d = '0;
        end
        check(res_i, exp_i, "fetch port result");
        check(res_d, exp_d, "data port result");
        n_cmp++;
        have_exp = rstn;
        if (!rstn) begin
            shadow_clear();
        end else begin
            exp_i = expected_xlat(pg, asid, dmw0, dmw1, va_i);
            exp_d = expected_xlat(pg, asid, dmw0, dmw1, va_d);
            shadow_write(wr);  // seen by lookups one edge later
        end
    end

    task automatic settle_and_report(input string name, input int err0);
        int target;
        int waited;
        target = n_cmp + 2;
        waited = 0;
        while (n_cmp < target && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (n_cmp < target) begin
            n_err++;
            $display("%s: results were not compared within 10 cycles", name);
        end
        n_tests++;
        $display("%s: done, %0d errors", name, n_err - err0);
    endtask

    // an address inside entry idx, page offset and odd bit random
    function automatic logic [`VA_LEN-1:0] pick_va(input logic [3:0] idx);
        logic [31:0] r;
        r = $random(seed);
        if (shadow[idx].cmp.ps == `PS_2M) begin
            return {shadow[idx].cmp.vppn[18:9], r[21:0]};
        end
        return {shadow[idx].cmp.vppn, r[12:0]};
    endfunction

    // vppn top bits equal the index, so no two entries overlap
    task automatic write_entry(input logic [3:0] idx, input bit big, input bit g);
        tlb_pkg::tlb_wr_t w;
        @(posedge clk);
        w = {1'b1, idx, 1'b1, asid, g, big ? 6'(`PS_2M) : 6'(`PS_4K), idx,
             15'($random(seed)), 26'($random(seed)), 26'($random(seed))};
        w.entry.odd.ppn[19] = ~w.entry.even.ppn[19];
        wr <= w;
    endtask

    task automatic drive_lookups(input int n, input int nent);
        logic [31:0] r;
        repeat (n) begin
            @(posedge clk);
            wr.we <= 1'b0;
            r = $random(seed);
            va_i <= r[0] ? pick_va(4'(r[7:1] % nent)) : $random(seed);
            va_d <= r[8] ? pick_va(4'(r[15:9] % nent)) : $random(seed);
        end
    endtask

    initial begin
        int err0;
        logic [31:0] r;
        logic [`VA_LEN-1:0] old_va;
        seed = 9076;
        clk = 1'b0;
        rstn = 1'b0;
        pg = 1'b0;
        asid = 10'h012;
        dmw0 = '0;
        dmw1 = '0;
        wr = '0;
        va_i = '0;
        va_d = '0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        err0 = n_err;
        drive_lookups(20, 1);
        settle_and_report("reset and direct mode", err0);

        err0 = n_err;
        @(posedge clk);
        pg <= 1'b1;
        dmw0 <= {1'b1, 3'b100, 3'b000};
        dmw1 <= {1'b1, 3'b101, 3'b001};
        drive_lookups(30, 1);
        @(posedge clk);
        dmw1 <= {1'b1, 3'b100, 3'b111};  // same segment as dmw0
        va_i <= 32'h8123_4567;
        drive_lookups(10, 1);
        settle_and_report("direct map windows", err0);

        err0 = n_err;
        @(posedge clk);
        dmw0 <= '0;
        dmw1 <= '0;
        for (int k = 0; k < 6; k++) begin
            write_entry(4'(k), 1'b0, 1'b0);
        end
        drive_lookups(40, 6);
        settle_and_report("4k pages", err0);

        err0 = n_err;
        for (int k = 6; k < 12; k++) begin
            write_entry(4'(k), 1'b1, k[0]);  // odd ones global
        end
        drive_lookups(30, 12);
        @(posedge clk);
        asid <= 10'h2a5;
        drive_lookups(30, 12);
        settle_and_report("2m pages and asid", err0);

        err0 = n_err;
        old_va = pick_va(4'd7);
        write_entry(4'd7, 1'b0, 1'b1);
        va_i <= old_va;
        va_d <= old_va;
        @(posedge clk);
        wr.we <= 1'b0;
        va_d <= pick_va(4'd7);
        settle_and_report("write timing", err0);

        err0 = n_err;
        repeat (400) begin
            r = $random(seed);
            if (r[0]) begin
                write_entry(r[4:1], r[5], r[6]);
            end else begin
                @(posedge clk);
                wr.we <= 1'b0;
            end
            pg <= r[9:7] != 3'd0;
            asid <= r[10] ? 10'h012 : 10'h2a5;
            dmw0 <= {r[11] & r[12], r[18:13]};
            dmw1 <= {r[19] & r[20], r[26:21]};
            va_i <= r[27] ? pick_va(r[31:28]) : $random(seed);
            va_d <= r[28] ? pick_va(r[4:1]) : $random(seed);
        end
        settle_and_report("random mix", err0);

        $display("tests %0d, cycles checked %0d, errors %0d", n_tests, n_cmp, n_err);
        if (n_err == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: source/mmu_top.sv
`timescale 1ns/10ps
`include "tlb_consts.svh"

module mmu_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        pg,
    input  logic [`TLB_ASID_LEN-1:0]    asid,
    input  tlb_pkg::dmw_t               dmw0,
    input  tlb_pkg::dmw_t               dmw1,
    input  tlb_pkg::tlb_wr_t            wr,
    input  logic [`VA_LEN-1:0]          va_i,
    input  logic [`VA_LEN-1:0]          va_d,
    output tlb_pkg::xlat_res_t          res_i,
    output tlb_pkg::xlat_res_t          res_d
);

    tlb_pkg::tlb_entry_t entries [`TLB_NUM];  // shared by both ports

    tlb_entry_array u_entries (
        .clk     (clk),
        .rstn    (rstn),
        .wr      (wr),
        .entries (entries)
    );

    // fetch port
    addr_translate u_xlat_i (
        .clk     (clk),
        .rstn    (rstn),
        .pg      (pg),
        .asid    (asid),
        .dmw0    (dmw0),
        .dmw1    (dmw1),
        .entries (entries),
        .va      (va_i),
        .res     (res_i)
    );

    // data port
    addr_translate u_xlat_d (
        .clk     (clk),
        .rstn    (rstn),
        .pg      (pg),
        .asid    (asid),
        .dmw0    (dmw0),
        .dmw1    (dmw1),
        .entries (entries),
        .va      (va_d),
        .res     (res_d)
    );

endmodule

// File: source/addr_translate.sv
`timescale 1ns/10ps
`include "tlb_consts.svh"

module addr_translate (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        pg,
    input  logic [`TLB_ASID_LEN-1:0]    asid,
    input  tlb_pkg::dmw_t               dmw0,
    input  tlb_pkg::dmw_t               dmw1,
    input  tlb_pkg::tlb_entry_t         entries [`TLB_NUM],
    input  logic [`VA_LEN-1:0]          va,
    output tlb_pkg::xlat_res_t          res
);

    tlb_pkg::xlat_mode_e    mode_d;
    tlb_pkg::xlat_mode_e    mode_q;
    logic [`VA_LEN-1:0]     fix_pa_d;   // direct or window pa
    logic [`VA_LEN-1:0]     fix_pa_q;
    logic [`PS_2M-1:0]      va_lo_q;    // page offset, up to 2m
    logic                   vld_q;      // a lookup was issued since reset
    logic                   tlb_hit;
    tlb_pkg::tlb_trans_t    tlb_half;
    logic                   tlb_ps_2m;

    tlb_lookup u_lookup (
        .clk     (clk),
        .rstn    (rstn),
        .entries (entries),
        .asid    (asid),
        .va      (va),
        .hit     (tlb_hit),
        .half    (tlb_half),
        .ps_2m   (tlb_ps_2m)
    );

    // dmw0 wins over dmw1
    always_comb begin
        fix_pa_d = va;
        if (!pg) begin
            mode_d = tlb_pkg::mode_direct;
        end else if (dmw0.en && va[`VA_LEN-1 -: `DMW_SEG_LEN] == dmw0.vseg) begin
            mode_d   = tlb_pkg::mode_dmw;
            fix_pa_d = {dmw0.pseg, va[`VA_LEN-`DMW_SEG_LEN-1:0]};
        end else if (dmw1.en && va[`VA_LEN-1 -: `DMW_SEG_LEN] == dmw1.vseg) begin
            mode_d   = tlb_pkg::mode_dmw;
            fix_pa_d = {dmw1.pseg, va[`VA_LEN-`DMW_SEG_LEN-1:0]};
        end else begin
            mode_d = tlb_pkg::mode_paged;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode_q <= tlb_pkg::mode_direct;
            vld_q  <= 1'b0;
        end else begin
            mode_q <= mode_d;
            vld_q  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        fix_pa_q <= fix_pa_d;
        va_lo_q  <= va[`PS_2M-1:0];
    end

    always_comb begin
        res      = '0;
        res.mode = mode_q;
        if (mode_q != tlb_pkg::mode_paged) begin
            if (vld_q) begin
                res.hit = 1'b1;
                res.pa  = fix_pa_q;
            end
        end else if (tlb_hit) begin
            res.hit = 1'b1;
            res.v   = tlb_half.v;   // page-invalid left to the consumer
            res.d   = tlb_half.d;
            res.mat = tlb_half.mat;
            res.plv = tlb_half.plv;
            if (tlb_ps_2m) begin
                res.pa = {tlb_half.ppn[`TLB_PPN_LEN-1:`PS_2M-`PS_4K], va_lo_q};
            end else begin
                res.pa = {tlb_half.ppn, va_lo_q[`PS_4K-1:0]};
            end
        end else begin
            res.miss = 1'b1;
        end
    end

    a_hit_miss_excl: assert property (
        @(posedge clk) disable iff (!rstn)
        !(res.hit && res.miss)
    ) else $error("hit and miss both set");

endmodule

// File: tlb/tlb_lookup.sv
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_lookup (
    input  logic                        clk,
    input  logic                        rstn,
    input  tlb_pkg::tlb_entry_t         entries [`TLB_NUM],
    input  logic [`TLB_ASID_LEN-1:0]    asid,
    input  logic [`VA_LEN-1:0]          va,
    output logic                        hit,
    output tlb_pkg::tlb_trans_t         half,
    output logic                        ps_2m
);

    // compare stage
    logic [`TLB_NUM-1:0]    id_ok;    // enabled and asid or global
    logic [`TLB_NUM-1:0]    hit_4k;
    logic [`TLB_NUM-1:0]    hit_2m;
    logic [`TLB_NUM-1:0]    is_4k;

    // stage register
    logic [`TLB_NUM-1:0]    hit_4k_q;
    logic [`TLB_NUM-1:0]    hit_2m_q;
    logic [`TLB_NUM-1:0]    is_4k_q;
    logic                   odd_4k_q;
    logic                   odd_2m_q;
    tlb_pkg::tlb_trans_t    even_q [`TLB_NUM];
    tlb_pkg::tlb_trans_t    odd_q  [`TLB_NUM];

    // select stage
    logic [`TLB_NUM-1:0]    hit_vec;
    logic [`TLB_NUM-1:0]    odd_vec;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            id_ok[i]  = entries[i].cmp.e &
                        (entries[i].cmp.g | (entries[i].cmp.asid == asid));
            hit_4k[i] = id_ok[i] &
                        (entries[i].cmp.vppn == va[`VA_LEN-1:`PS_4K+1]);
            // 2m pages ignore the low vppn bits
            hit_2m[i] = id_ok[i] &
                        (entries[i].cmp.vppn[`TLB_VPPN_LEN-1:`PS_2M-`PS_4K] ==
                         va[`VA_LEN-1:`PS_2M+1]);
            is_4k[i]  = (entries[i].cmp.ps == `PS_4K);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hit_4k_q <= '0;
            hit_2m_q <= '0;
            is_4k_q  <= '0;
        end else begin
            hit_4k_q <= hit_4k;
            hit_2m_q <= hit_2m;
            is_4k_q  <= is_4k;
        end
    end

    always_ff @(posedge clk) begin
        odd_4k_q <= va[`PS_4K];
        odd_2m_q <= va[`PS_2M];
        for (int i = 0; i < `TLB_NUM; i++) begin
            even_q[i] <= entries[i].even;
            odd_q[i]  <= entries[i].odd;
        end
    end

    // one-hot or of the selected halves
    always_comb begin
        half = '0;
        for (int i = 0; i < `TLB_NUM; i++) begin
            hit_vec[i] = is_4k_q[i] ? hit_4k_q[i] : hit_2m_q[i];
            odd_vec[i] = is_4k_q[i] ? odd_4k_q : odd_2m_q;
            if (hit_vec[i]) begin
                half = tlb_pkg::tlb_trans_t'(half | (odd_vec[i] ? odd_q[i] : even_q[i]));
            end
        end
    end

    assign hit   = |hit_vec;
    assign ps_2m = |(hit_vec & ~is_4k_q);

    // overlapping entries would or two halves together
    a_hit_onehot0: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(hit_vec)
    ) else $error("multiple tlb hits");

endmodule

// File: tlb/tlb_entry_array.sv
`timescale 1ns/10ps
`include "tlb_consts.svh"

module tlb_entry_array (
    input  logic                clk,
    input  logic                rstn,
    input  tlb_pkg::tlb_wr_t    wr,
    output tlb_pkg::tlb_entry_t entries [`TLB_NUM]
);

    logic [`TLB_NUM-1:0]    e_q;               // entry enables, cleared on reset
    tlb_pkg::tlb_entry_t    mem_q [`TLB_NUM];  // compare and translate fields

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            e_q <= '0;
        end else if (wr.we) begin
            e_q[wr.index] <= wr.entry.cmp.e;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem_q[wr.index] <= wr.entry;  // tlbwr style, by index
        end
    end

    // stored e bit is shadowed by e_q
    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            entries[i]       = mem_q[i];
            entries[i].cmp.e = e_q[i];
        end
    end

    // a write with an unknown index would corrupt an arbitrary entry
    a_wr_index_known: assert property (
        @(posedge clk) disable iff (!rstn)
        wr.we |-> !$isunknown(wr.index)
    ) else $error("tlb write with unknown index");

endmodule

// File: common/tlb_pkg.sv
`include "tlb_consts.svh"

package tlb_pkg;

    typedef struct packed {
        logic                       e;
        logic [`TLB_ASID_LEN-1:0]   asid;
        logic                       g;
        logic [`TLB_PS_LEN-1:0]     ps;      // 12 or 21
        logic [`TLB_VPPN_LEN-1:0]   vppn;
    } tlb_cmp_t;

    typedef struct packed {
        logic                       v;
        logic                       d;
        logic [1:0]                 mat;
        logic [1:0]                 plv;
        logic [`TLB_PPN_LEN-1:0]    ppn;
    } tlb_trans_t;

    typedef struct packed {
        tlb_cmp_t                   cmp;
        tlb_trans_t                 even;
        tlb_trans_t                 odd;
    } tlb_entry_t;

    typedef struct packed {
        logic                       we;
        logic [`TLB_IDX_LEN-1:0]    index;
        tlb_entry_t                 entry;
    } tlb_wr_t;

    typedef struct packed {
        logic                       en;
        logic [`DMW_SEG_LEN-1:0]    vseg;
        logic [`DMW_SEG_LEN-1:0]    pseg;
    } dmw_t;

    typedef enum logic [1:0] {
        mode_direct = 2'd0,
        mode_dmw    = 2'd1,
        mode_paged  = 2'd2
    } xlat_mode_e;

    typedef struct packed {
        xlat_mode_e                 mode;
        logic                       hit;
        logic                       miss;
        logic [`VA_LEN-1:0]         pa;
        logic                       v;
        logic                       d;
        logic [1:0]                 mat;
        logic [1:0]                 plv;
    } xlat_res_t;

endpackage

// File: common/tlb_consts.svh
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// tlb geometry
`define TLB_NUM         16
`define TLB_IDX_LEN     4

// entry field widths
`define TLB_VPPN_LEN    19  // va[31:13]
`define TLB_PPN_LEN     20
`define TLB_ASID_LEN    10
`define TLB_PS_LEN      6

// page size encodings, also the low bit of the odd select
`define PS_4K           12
`define PS_2M           21

// address and window segment widths
`define VA_LEN          32
`define DMW_SEG_LEN     3   // top bits that pick a window

`endif
